// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= seg_game_tb
FILELIST   ?= src.f
FLAGS      ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_TEXT  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== src.f ====
src/seg_game_pkg.sv
src/button_conditioner.sv
src/move_fifo.sv
src/segment_walker.sv
src/seg_game_top.sv
tb/seg_game_tb.sv

// ==== src/button_conditioner.sv ====
`timescale 1ns/1ps

module button_conditioner (
    input  logic                clk,
    input  logic                rst,
    input  logic                btn_right,
    input  logic                btn_left,
    input  logic                btn_up,
    input  logic                btn_down,
    output logic                wr_cyc,
    output logic                wr_stb,
    output seg_game_pkg::move_e wr_dat,
    input  logic                wr_ack
);
    import seg_game_pkg::*;

    logic [3:0]                   btn;
    logic [3:0][DEBOUNCE_LEN-1:0] shreg;
    logic [3:0]                   level;
    logic [3:0]                   level_q;
    logic [3:0]                   rise;
    logic                         pending;
    move_e                        sel;

    // Index order matches the move codes, right at bit 0
    assign btn = {btn_down, btn_up, btn_left, btn_right};

    // Debounced level once the whole window is high
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            level[i] = &shreg[i];
        end
    end

    assign rise = level & ~level_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shreg   <= '0;
            level_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                shreg[i] <= {shreg[i][DEBOUNCE_LEN-2:0], btn[i]};
            end
            level_q <= level;
        end
    end

    // Lowest index wins, so right beats left, up and down
    always_comb begin
        sel = MV_DOWN;
        for (int i = 3; i >= 0; i--) begin
            if (rise[i]) begin
                sel = move_e'(2'(i));
            end
        end
    end

    // Single pending write, new edges are dropped while it is out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (pending) begin
            if (wr_ack) begin
                pending <= 1'b0;
            end
        end else if (|rise) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!pending && |rise) begin
            wr_dat <= sel;
        end
    end

    assign wr_cyc = pending;
    assign wr_stb = pending;

endmodule

// ==== src/move_fifo.sv ====
`timescale 1ns/1ps

module move_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_cyc,
    input  logic                wr_stb,
    input  seg_game_pkg::move_e wr_dat,
    output logic                wr_ack,
    input  logic                rd_cyc,
    input  logic                rd_stb,
    output seg_game_pkg::move_e rd_dat,
    output logic                rd_ack
);
    import seg_game_pkg::*;

    move_e                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  full;
    logic                  empty;
    logic                  wr_go;
    logic                  rd_go;

    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Each request is taken once, the ack cycle itself is not a new request
    assign wr_go = wr_cyc & wr_stb & ~wr_ack & ~full;
    assign rd_go = rd_cyc & rd_stb & ~rd_ack & ~empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ack <= wr_go;
            rd_ack <= rd_go;
            if (wr_go) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_go) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + FIFO_CNT_W'(wr_go) - FIFO_CNT_W'(rd_go);
        end
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (wr_go) begin
            mem[wr_ptr] <= wr_dat;
        end
        if (rd_go) begin
            rd_dat <= mem[rd_ptr];
        end
    end

endmodule

// ==== src/seg_game_pkg.sv ====
package seg_game_pkg;

    localparam int TICK_CYCLES  = 8;
    localparam int INIT_TICKS   = 3;
    localparam int FALL_TICKS   = 2;
    localparam int DEBOUNCE_LEN = 4;
    localparam int FIFO_DEPTH   = 4;

    localparam int TICK_CNT_W = $clog2(TICK_CYCLES);
    localparam int TICKS_W    = $clog2((INIT_TICKS > FALL_TICKS ? INIT_TICKS : FALL_TICKS) + 1);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        MV_RIGHT = 2'd0,
        MV_LEFT  = 2'd1,
        MV_UP    = 2'd2,
        MV_DOWN  = 2'd3
    } move_e;

    typedef enum logic [1:0] {
        HD_RIGHT = 2'd0,
        HD_LEFT  = 2'd1,
        HD_UP    = 2'd2,
        HD_DOWN  = 2'd3
    } head_e;

    // Bit index into the segment vector
    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_idx_e;

    typedef enum logic [1:0] {
        ST_INITIAL = 2'd0,
        ST_MOVING  = 2'd1,
        ST_FALLING = 2'd2
    } game_state_e;

    typedef struct packed {
        logic     valid;
        seg_idx_e pos;
        head_e    head;
    } step_t;

    // Cursor step table, keyed on position, heading and button
    function automatic step_t move_step(seg_idx_e cur_pos, head_e cur_head, move_e mv);
        step_t step;
        step = '{1'b0, cur_pos, cur_head};
        case ({cur_pos, cur_head, mv})
            {SEG_A, HD_RIGHT, MV_RIGHT}: step = '{1'b1, SEG_B, HD_DOWN};
            {SEG_A, HD_LEFT,  MV_LEFT}:  step = '{1'b1, SEG_F, HD_DOWN};
            {SEG_B, HD_UP,    MV_LEFT}:  step = '{1'b1, SEG_A, HD_LEFT};
            {SEG_B, HD_DOWN,  MV_RIGHT}: step = '{1'b1, SEG_G, HD_LEFT};
            {SEG_B, HD_DOWN,  MV_UP}:    step = '{1'b1, SEG_C, HD_DOWN};
            {SEG_C, HD_UP,    MV_LEFT}:  step = '{1'b1, SEG_G, HD_LEFT};
            {SEG_C, HD_UP,    MV_UP}:    step = '{1'b1, SEG_B, HD_UP};
            {SEG_C, HD_DOWN,  MV_RIGHT}: step = '{1'b1, SEG_D, HD_DOWN};
            {SEG_D, HD_RIGHT, MV_LEFT}:  step = '{1'b1, SEG_C, HD_UP};
            {SEG_D, HD_LEFT,  MV_RIGHT}: step = '{1'b1, SEG_E, HD_UP};
            {SEG_E, HD_UP,    MV_RIGHT}: step = '{1'b1, SEG_G, HD_RIGHT};
            {SEG_E, HD_UP,    MV_UP}:    step = '{1'b1, SEG_F, HD_UP};
            {SEG_E, HD_DOWN,  MV_LEFT}:  step = '{1'b1, SEG_D, HD_RIGHT};
            {SEG_F, HD_UP,    MV_RIGHT}: step = '{1'b1, SEG_A, HD_RIGHT};
            {SEG_F, HD_DOWN,  MV_LEFT}:  step = '{1'b1, SEG_G, HD_RIGHT};
            {SEG_G, HD_RIGHT, MV_LEFT}:  step = '{1'b1, SEG_B, HD_UP};
            {SEG_G, HD_RIGHT, MV_RIGHT}: step = '{1'b1, SEG_C, HD_DOWN};
            {SEG_G, HD_LEFT,  MV_LEFT}:  step = '{1'b1, SEG_E, HD_DOWN};
            {SEG_G, HD_LEFT,  MV_RIGHT}: step = '{1'b1, SEG_F, HD_UP};
            default:                     step.valid = 1'b0;
        endcase
        return step;
    endfunction

endpackage

// ==== src/seg_game_top.sv ====
`timescale 1ns/1ps

module seg_game_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      btn_right,
    input  logic                      btn_left,
    input  logic                      btn_up,
    input  logic                      btn_down,
    output logic [6:0]                seg,
    output seg_game_pkg::seg_idx_e    pos,
    output seg_game_pkg::head_e       head,
    output seg_game_pkg::game_state_e game_state
);
    import seg_game_pkg::*;

    logic  wr_cyc;
    logic  wr_stb;
    move_e wr_dat;
    logic  wr_ack;
    logic  rd_cyc;
    logic  rd_stb;
    move_e rd_dat;
    logic  rd_ack;

    button_conditioner u_cond (
        .clk       (clk),
        .rst       (rst),
        .btn_right (btn_right),
        .btn_left  (btn_left),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .wr_cyc    (wr_cyc),
        .wr_stb    (wr_stb),
        .wr_dat    (wr_dat),
        .wr_ack    (wr_ack)
    );

    move_fifo u_fifo (
        .clk    (clk),
        .rst    (rst),
        .wr_cyc (wr_cyc),
        .wr_stb (wr_stb),
        .wr_dat (wr_dat),
        .wr_ack (wr_ack),
        .rd_cyc (rd_cyc),
        .rd_stb (rd_stb),
        .rd_dat (rd_dat),
        .rd_ack (rd_ack)
    );

    segment_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .rd_cyc     (rd_cyc),
        .rd_stb     (rd_stb),
        .rd_dat     (rd_dat),
        .rd_ack     (rd_ack),
        .seg        (seg),
        .pos        (pos),
        .head       (head),
        .game_state (game_state)
    );

endmodule

// ==== src/segment_walker.sv ====
`timescale 1ns/1ps

module segment_walker (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      rd_cyc,
    output logic                      rd_stb,
    input  seg_game_pkg::move_e       rd_dat,
    input  logic                      rd_ack,
    output logic [6:0]                seg,
    output seg_game_pkg::seg_idx_e    pos,
    output seg_game_pkg::head_e       head,
    output seg_game_pkg::game_state_e game_state
);
    import seg_game_pkg::*;

    logic [TICK_CNT_W-1:0] tick_cnt;
    logic                  tick;
    logic [TICKS_W-1:0]    ticks;
    logic [6:0]            record;
    logic [6:0]            record_step;
    logic                  blink;
    logic                  rd_req;
    logic                  in_play;
    logic                  fall_on;
    logic                  init_done;
    logic                  fall_done;
    step_t                 step;

    assign tick    = (tick_cnt == TICK_CNT_W'(TICK_CYCLES - 1));
    assign in_play = (game_state == ST_MOVING) || (game_state == ST_FALLING);

    // Fall timer runs once every segment has been visited
    assign fall_on   = (game_state == ST_FALLING) && (record == '0);
    assign init_done = (game_state == ST_INITIAL) && tick
                       && (ticks == TICKS_W'(INIT_TICKS - 1));
    assign fall_done = fall_on && tick && (ticks == TICKS_W'(FALL_TICKS - 1));

    assign step        = move_step(pos, head, rd_dat);
    assign record_step = record & ~(7'b1 << step.pos);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state <= ST_INITIAL;
            pos        <= SEG_G;
            head       <= HD_LEFT;
            record     <= '1;
            tick_cnt   <= '0;
            ticks      <= '0;
            blink      <= 1'b1;
            rd_req     <= 1'b0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick) begin
                blink <= ~blink;
            end
            if (tick && (game_state == ST_INITIAL || fall_on)) begin
                ticks <= ticks + 1'b1;
            end

            // Request held until acked and idle while the fall timer runs
            rd_req <= in_play && !fall_on && !rd_ack;

            case (game_state)
                ST_INITIAL: begin
                    if (init_done) begin
                        game_state <= ST_MOVING;
                    end
                end
                ST_MOVING: begin
                    // Only down starts the walk
                    if (rd_ack && rd_dat == MV_DOWN) begin
                        game_state     <= ST_FALLING;
                        record[SEG_G]  <= 1'b0;
                    end
                end
                ST_FALLING: begin
                    if (fall_done) begin
                        game_state <= ST_INITIAL;
                        pos        <= SEG_G;
                        head       <= HD_LEFT;
                        record     <= '1;
                        tick_cnt   <= '0;
                        ticks      <= '0;
                    end else if (rd_ack && step.valid) begin
                        pos    <= step.pos;
                        head   <= step.head;
                        record <= record_step;
                        // Fall timer starts when the last segment clears
                        if (record_step == '0) begin
                            tick_cnt <= '0;
                            ticks    <= '0;
                        end
                    end
                end
                default: begin
                    game_state <= ST_INITIAL;
                end
            endcase
        end
    end

    assign rd_cyc = rd_req;
    assign rd_stb = rd_req;

    // Cursor segment blinks over the visit record
    always_comb begin
        seg        = '0;
        seg[SEG_G] = 1'b1;
        if (game_state == ST_FALLING) begin
            seg      = record;
            seg[pos] = blink;
        end
    end

endmodule

// ==== tb/seg_game_tb.sv ====
`timescale 1ns/1ps

module seg_game_tb;
    import seg_game_pkg::*;

    localparam int          TIMEOUT_CYCLES = 6000;
    localparam int          SETTLE_CYCLES  = 3 * TICK_CYCLES;
    localparam logic [31:0] SEED           = 32'h53f65cba;

    // Columns: pos, head, button, next pos, next head
    localparam logic [11:0] STEP_ROWS [19] = '{
        {SEG_A, HD_RIGHT, MV_RIGHT, SEG_B, HD_DOWN},
        {SEG_A, HD_LEFT,  MV_LEFT,  SEG_F, HD_DOWN},
        {SEG_B, HD_UP,    MV_LEFT,  SEG_A, HD_LEFT},
        {SEG_B, HD_DOWN,  MV_RIGHT, SEG_G, HD_LEFT},
        {SEG_B, HD_DOWN,  MV_UP,    SEG_C, HD_DOWN},
        {SEG_C, HD_UP,    MV_LEFT,  SEG_G, HD_LEFT},
        {SEG_C, HD_UP,    MV_UP,    SEG_B, HD_UP},
        {SEG_C, HD_DOWN,  MV_RIGHT, SEG_D, HD_DOWN},
        {SEG_D, HD_RIGHT, MV_LEFT,  SEG_C, HD_UP},
        {SEG_D, HD_LEFT,  MV_RIGHT, SEG_E, HD_UP},
        {SEG_E, HD_UP,    MV_RIGHT, SEG_G, HD_RIGHT},
        {SEG_E, HD_UP,    MV_UP,    SEG_F, HD_UP},
        {SEG_E, HD_DOWN,  MV_LEFT,  SEG_D, HD_RIGHT},
        {SEG_F, HD_UP,    MV_RIGHT, SEG_A, HD_RIGHT},
        {SEG_F, HD_DOWN,  MV_LEFT,  SEG_G, HD_RIGHT},
        {SEG_G, HD_RIGHT, MV_LEFT,  SEG_B, HD_UP},
        {SEG_G, HD_RIGHT, MV_RIGHT, SEG_C, HD_DOWN},
        {SEG_G, HD_LEFT,  MV_LEFT,  SEG_E, HD_DOWN},
        {SEG_G, HD_LEFT,  MV_RIGHT, SEG_F, HD_UP}
    };

    logic        clk;
    logic        rst;
    logic        btn_right;
    logic        btn_left;
    logic        btn_up;
    logic        btn_down;
    logic [6:0]  seg;
    seg_idx_e    pos;
    head_e       head;
    game_state_e game_state;

    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_count;
    int          test_errors;
    seg_idx_e    ref_pos;
    head_e       ref_head;
    logic [6:0]  ref_record;

    seg_game_top dut (
        .clk        (clk),
        .rst        (rst),
        .btn_right  (btn_right),
        .btn_left   (btn_left),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .seg        (seg),
        .pos        (pos),
        .head       (head),
        .game_state (game_state)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic bit ref_step(input seg_idx_e p, input head_e h, input move_e m,
                                    output seg_idx_e np, output head_e nh);
        bit found;
        found = 1'b0;
        np = p;
        nh = h;
        for (int i = 0; i < 19; i++) begin
            if (STEP_ROWS[i][11:5] == {p, h, m}) begin
                np = seg_idx_e'(STEP_ROWS[i][4:2]);
                nh = head_e'(STEP_ROWS[i][1:0]);
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("error: t=%0t %s got %0h expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("t=%0t: %s", $time, what);
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (error_count == test_errors) ? "ok" : "failed");
        test_errors = error_count;
    endtask

    task automatic set_button(input move_e mv, input logic val);
        case (mv)
            MV_RIGHT: btn_right <= val;
            MV_LEFT:  btn_left  <= val;
            MV_UP:    btn_up    <= val;
            default:  btn_down  <= val;
        endcase
    endtask

    task automatic hold_button(input move_e mv, input int high_cycles, input int low_cycles);
        @(posedge clk);
        set_button(mv, 1'b1);
        repeat (high_cycles) @(posedge clk);
        set_button(mv, 1'b0);
        repeat (low_cycles) @(posedge clk);
    endtask

    task automatic press(input move_e mv);
        hold_button(mv, DEBOUNCE_LEN + 2, DEBOUNCE_LEN + 2);
    endtask

    task automatic wait_change(input seg_idx_e p0, input head_e h0, input game_state_e s0,
                               input int bound, output bit changed);
        int n;
        changed = 1'b0;
        n = 0;
        while (!changed && n < bound) begin
            @(negedge clk);
            changed = (pos != p0) || (head != h0) || (game_state != s0);
            n++;
        end
    endtask

    task automatic wait_state(input game_state_e target, input int bound);
        int n;
        n = 0;
        while (game_state != target && n < bound) begin
            @(negedge clk);
            n++;
        end
    endtask

    // One press in FALLING, checked against the reference table and record
    task automatic steer(input move_e mv);
        seg_idx_e    p0;
        head_e       h0;
        game_state_e s0;
        seg_idx_e    np;
        head_e       nh;
        bit          valid;
        bit          changed;
        @(negedge clk);
        p0 = pos;
        h0 = head;
        s0 = game_state;
        valid = ref_step(ref_pos, ref_head, mv, np, nh);
        press(mv);
        wait_change(p0, h0, s0, SETTLE_CYCLES, changed);
        if (valid) begin
            ref_pos = np;
            ref_head = nh;
            ref_record[np] = 1'b0;
        end
        check_true(changed == valid, valid ? "valid move left the cursor unchanged"
                                           : "invalid move changed the cursor");
        check_val("pos", int'(pos), int'(ref_pos));
        check_val("head", int'(head), int'(ref_head));
        check_val("seg", int'(seg & ~(7'b1 << pos)), int'(ref_record));
    endtask

    task automatic reset_test();
        int n;
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("game_state", int'(game_state), int'(ST_INITIAL));
        check_val("seg", int'(seg), 7'b1000000);
        check_val("pos", int'(pos), int'(SEG_G));
        check_val("head", int'(head), int'(HD_LEFT));
        n = 0;
        while (game_state != ST_MOVING && n < 2 * INIT_TICKS * TICK_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end
        check_val("cycles_to_moving", n, INIT_TICKS * TICK_CYCLES);
        report_test("reset and initial");
    endtask

    task automatic moving_filter_test();
        move_e others [3] = '{MV_RIGHT, MV_LEFT, MV_UP};
        bit    changed;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            press(others[i]);
            wait_change(SEG_G, HD_LEFT, ST_MOVING, SETTLE_CYCLES, changed);
            check_true(!changed, "move other than down changed state or cursor in MOVING");
        end
        press(MV_DOWN);
        wait_change(SEG_G, HD_LEFT, ST_MOVING, SETTLE_CYCLES, changed);
        check_val("game_state", int'(game_state), int'(ST_FALLING));
        check_val("pos", int'(pos), int'(SEG_G));
        check_val("head", int'(head), int'(HD_LEFT));
        check_val("seg", int'(seg & 7'b0111111), 7'b0111111);
        ref_pos = SEG_G;
        ref_head = HD_LEFT;
        ref_record = 7'b0111111;
        report_test("moving filter");
    endtask

    // Visits e, d, c and comes back to g, leaving a, b and f
    task automatic steering_test();
        move_e moves [8] = '{MV_DOWN, MV_LEFT, MV_UP, MV_LEFT,
                             MV_RIGHT, MV_LEFT, MV_DOWN, MV_LEFT};
        for (int i = 0; i < 8; i++) begin
            steer(moves[i]);
        end
        report_test("steering");
    endtask

    task automatic tour_test();
        move_e moves [6] = '{MV_LEFT, MV_LEFT, MV_LEFT, MV_UP, MV_LEFT, MV_LEFT};
        for (int i = 0; i < 6; i++) begin
            steer(moves[i]);
        end
        wait_state(ST_INITIAL, FALL_TICKS * TICK_CYCLES + 4);
        check_true(game_state == ST_INITIAL, "game did not return to INITIAL after the fall");
        check_val("seg", int'(seg), 7'b1000000);
        check_val("pos", int'(pos), int'(SEG_G));
        check_val("head", int'(head), int'(HD_LEFT));
        wait_state(ST_MOVING, INIT_TICKS * TICK_CYCLES + 4);
        check_true(game_state == ST_MOVING, "game did not reach MOVING again after INITIAL");
        report_test("full tour and return");
    endtask

    task automatic debounce_test();
        int       len;
        int       gap;
        bit       changed;
        bit       valid;
        seg_idx_e np;
        head_e    nh;
        @(negedge clk);
        press(MV_DOWN);
        wait_change(SEG_G, HD_LEFT, ST_MOVING, SETTLE_CYCLES, changed);
        check_val("game_state", int'(game_state), int'(ST_FALLING));
        ref_pos = SEG_G;
        ref_head = HD_LEFT;
        ref_record = 7'b0111111;
        // Glitches shorter than the debounce window
        repeat (8) begin
            len = 1 + int'($urandom % (DEBOUNCE_LEN - 1));
            gap = 1 + int'($urandom % DEBOUNCE_LEN);
            hold_button(MV_LEFT, len, gap);
        end
        wait_change(SEG_G, HD_LEFT, ST_FALLING, SETTLE_CYCLES, changed);
        check_true(!changed, "short glitches produced a move");
        valid = ref_step(ref_pos, ref_head, MV_LEFT, np, nh);
        hold_button(MV_LEFT, 10 * DEBOUNCE_LEN, DEBOUNCE_LEN + 2);
        wait_change(SEG_G, HD_LEFT, ST_FALLING, SETTLE_CYCLES, changed);
        check_true(changed && valid, "long hold produced no move");
        ref_record[np] = 1'b0;
        check_val("pos", int'(pos), int'(np));
        check_val("head", int'(head), int'(nh));
        check_val("seg", int'(seg & ~(7'b1 << pos)), int'(ref_record));
        report_test("debounce");
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        rst = 1'b1;
        btn_right = 1'b0;
        btn_left = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        test_errors = 0;
        ref_pos = SEG_G;
        ref_head = HD_LEFT;
        ref_record = 7'b1111111;
        reset_test();
        moving_filter_test();
        steering_test();
        tour_test();
        debounce_test();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
